/* design/event_counter.sv */
`timescale 1ns/1ps
`include "mem_bus_settings.svh"

module event_counter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  sel,
    input  mem_bus_pkg::mem_req_t req_bus,
    output mem_bus_pkg::mem_rsp_t rsp,
    input  logic                  event_in,
    output logic                  irq
);
    import mem_bus_pkg::*;

    logic [`MEM_BUS_DATA_WID-1:0]   count_q;
    logic [`MEM_BUS_DATA_WID-1:0]   count_nxt;
    logic [`MEM_BUS_DATA_WID-1:0]   compare_q;
    logic [`MEM_BUS_DATA_WID-1:0]   rd_mux;
    logic [`MEM_BUS_DATA_WID-1:0]   rd_q;
    logic [`MEM_BUS_OFFSET_WID-1:0] offset;
    logic                            match_q;
    logic                            match_nxt;
    logic                            ack_q;
    logic                            load;
    logic                            cmp_wr;
    logic                            clr;

    assign offset = req_bus.addr.fields.offset;

    always_comb begin
        load   = sel && req_bus.wr && (offset == 0);
        cmp_wr = sel && req_bus.wr && (offset == 1);
        clr    = sel && req_bus.wr && (offset == 2) && req_bus.wr_data[0];

        count_nxt = count_q;
        if (load) begin
            count_nxt = req_bus.wr_data; // Load wins over an event.
        end else if (event_in) begin
            count_nxt = count_q + 1'b1;
        end

        match_nxt = match_q;
        if (clr) begin
            match_nxt = 1'b0;
        end
        if ((load || event_in) && (count_nxt == compare_q)) begin
            match_nxt = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q   <= '0;
            compare_q <= '0;
            match_q   <= 1'b0;
            ack_q     <= 1'b0;
        end else begin
            count_q <= count_nxt;
            if (cmp_wr) begin
                compare_q <= req_bus.wr_data;
            end
            match_q <= match_nxt;
            ack_q   <= sel;
        end
    end

    assign irq = match_q; // Level interrupt straight from the flag.

    always_comb begin
        case (offset)
            0:       rd_mux = count_q;
            1:       rd_mux = compare_q;
            2:       rd_mux = {{(`MEM_BUS_DATA_WID-1){1'b0}}, match_q};
            default: rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (sel && !req_bus.wr) begin
            rd_q <= rd_mux;
        end
    end

    assign rsp.ack     = ack_q;
    assign rsp.rd_data = rd_q;

endmodule

/* design/mem_bus_ctrl.sv */
`timescale 1ns/1ps
`include "mem_bus_settings.svh"

module mem_bus_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req,
    input  logic                          wr,
    input  mem_bus_pkg::mem_addr_u        addr,
    input  logic [`MEM_BUS_DATA_WID-1:0] wr_data,
    output logic                          rdy,
    output logic                          wr_ack,
    output logic                          rd_ack,
    output logic [`MEM_BUS_DATA_WID-1:0] rd_data,
    output mem_bus_pkg::mem_req_t         req_bus,
    output logic                          ram_sel,
    output logic                          regs_sel,
    output logic                          cnt_sel,
    input  mem_bus_pkg::mem_rsp_t         ram_rsp,
    input  mem_bus_pkg::mem_rsp_t         regs_rsp,
    input  mem_bus_pkg::mem_rsp_t         cnt_rsp
);
    import mem_bus_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ack,
        st_respond
    } state_e;

    state_e                        state_q;
    mem_req_t                      req_q;
    logic                          unm_sel;
    logic                          unm_ack;
    logic                          rsp_ack;
    logic [`MEM_BUS_DATA_WID-1:0] rsp_data;
    logic [`MEM_BUS_DATA_WID-1:0] rd_data_q;
    logic                          accept;

    assign rdy    = (state_q == st_idle);
    assign accept = req && rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle:     if (accept) state_q <= st_wait_ack;
                st_wait_ack: if (rsp_ack) state_q <= st_respond;
                st_respond:  state_q <= st_idle;
                default:     state_q <= st_idle;
            endcase
        end
    end

    // Held stable on req_bus for the whole transaction.
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= '{wr: wr, addr: addr, wr_data: wr_data};
        end
    end

    assign req_bus = req_q;

    // One select pulse in the cycle after acceptance.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ram_sel  <= 1'b0;
            regs_sel <= 1'b0;
            cnt_sel  <= 1'b0;
            unm_sel  <= 1'b0;
            unm_ack  <= 1'b0;
        end else begin
            ram_sel  <= accept && (addr.fields.region == region_ram);
            regs_sel <= accept && (addr.fields.region == region_regs);
            cnt_sel  <= accept && (addr.fields.region == region_counter);
            unm_sel  <= accept && (addr.fields.region == region_unmapped);
            unm_ack  <= unm_sel; // Same slot as a peripheral ack.
        end
    end

    always_comb begin
        rsp_ack = ram_rsp.ack | regs_rsp.ack | cnt_rsp.ack | unm_ack;
        case (req_q.addr.fields.region)
            region_ram:     rsp_data = ram_rsp.rd_data;
            region_regs:    rsp_data = regs_rsp.rd_data;
            region_counter: rsp_data = cnt_rsp.rd_data;
            default:        rsp_data = `MEM_BUS_UNMAPPED_DATA;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state_q == st_wait_ack && rsp_ack) begin
            rd_data_q <= rsp_data;
        end
    end

    assign rd_data = rd_data_q;
    assign wr_ack  = (state_q == st_respond) && req_q.wr;
    assign rd_ack  = (state_q == st_respond) && !req_q.wr;

    // The merged ack relies on a single responder per cycle.
    a_one_rsp_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ram_rsp.ack, regs_rsp.ack, cnt_rsp.ack, unm_ack}));

    // Peripherals may only answer a select issued by this FSM.
    a_no_ack_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == st_idle) |-> !(ram_rsp.ack || regs_rsp.ack || cnt_rsp.ack));

endmodule

/* design/mem_bus_hub.sv */
`timescale 1ns/1ps
`include "mem_bus_settings.svh"

module mem_bus_hub (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req,
    input  logic                          wr,
    input  logic [`MEM_BUS_ADDR_WID-1:0] addr,
    input  logic [`MEM_BUS_DATA_WID-1:0] wr_data,
    output logic                          rdy,
    output logic                          wr_ack,
    output logic                          rd_ack,
    output logic [`MEM_BUS_DATA_WID-1:0] rd_data,
    input  logic                          event_in,
    output logic                          irq
);

    mem_bus_pkg::mem_req_t req_bus;
    mem_bus_pkg::mem_rsp_t ram_rsp;
    mem_bus_pkg::mem_rsp_t regs_rsp;
    mem_bus_pkg::mem_rsp_t cnt_rsp;
    logic                  ram_sel;
    logic                  regs_sel;
    logic                  cnt_sel;

    mem_bus_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .wr       (wr),
        .addr     (addr),
        .wr_data  (wr_data),
        .rdy      (rdy),
        .wr_ack   (wr_ack),
        .rd_ack   (rd_ack),
        .rd_data  (rd_data),
        .req_bus  (req_bus),
        .ram_sel  (ram_sel),
        .regs_sel (regs_sel),
        .cnt_sel  (cnt_sel),
        .ram_rsp  (ram_rsp),
        .regs_rsp (regs_rsp),
        .cnt_rsp  (cnt_rsp)
    );

    scratch_ram u_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .sel     (ram_sel),
        .req_bus (req_bus),
        .rsp     (ram_rsp)
    );

    reg_bank u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .sel     (regs_sel),
        .req_bus (req_bus),
        .rsp     (regs_rsp)
    );

    event_counter u_cnt (
        .clk      (clk),
        .rst_n    (rst_n),
        .sel      (cnt_sel),
        .req_bus  (req_bus),
        .rsp      (cnt_rsp),
        .event_in (event_in),
        .irq      (irq)
    );

endmodule

/* design/mem_bus_pkg.sv */
`include "mem_bus_settings.svh"

package mem_bus_pkg;

    // Region sits in the top two address bits.
    typedef enum logic [1:0] {
        region_ram      = 2'd0,
        region_regs     = 2'd1,
        region_counter  = 2'd2,
        region_unmapped = 2'd3
    } mem_region_e;

    typedef struct packed {
        mem_region_e                     region;
        logic [`MEM_BUS_OFFSET_WID-1:0] offset;
    } mem_addr_fields_t;

    // Raw word for the host side, split view for decode and indexing.
    typedef union packed {
        logic [`MEM_BUS_ADDR_WID-1:0] word;
        mem_addr_fields_t             fields;
    } mem_addr_u;

    typedef struct packed {
        logic                          wr;
        mem_addr_u                     addr;
        logic [`MEM_BUS_DATA_WID-1:0] wr_data;
    } mem_req_t;

    // Ack is a single-cycle pulse, rd_data valid with it.
    typedef struct packed {
        logic                          ack;
        logic [`MEM_BUS_DATA_WID-1:0] rd_data;
    } mem_rsp_t;

endpackage

/* design/reg_bank.sv */
`timescale 1ns/1ps
`include "mem_bus_settings.svh"

module reg_bank (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  sel,
    input  mem_bus_pkg::mem_req_t req_bus,
    output mem_bus_pkg::mem_rsp_t rsp
);
    import mem_bus_pkg::*;

    logic [3:0][`MEM_BUS_DATA_WID-1:0] scratch_q;
    logic [`MEM_BUS_DATA_WID-1:0]      rd_mux;
    logic [`MEM_BUS_DATA_WID-1:0]      rd_q;
    logic                               ack_q;
    logic [`MEM_BUS_OFFSET_WID-1:0]    offset;
    logic                               scratch_hit;

    assign offset      = req_bus.addr.fields.offset;
    assign scratch_hit = (offset[`MEM_BUS_OFFSET_WID-1:2] == '0); // Offsets 0..3.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scratch_q <= '0;
        end else if (sel && req_bus.wr && scratch_hit) begin
            scratch_q[offset[1:0]] <= req_bus.wr_data;
        end
    end

    always_comb begin
        if (scratch_hit) begin
            rd_mux = scratch_q[offset[1:0]];
        end else if (offset == 4) begin
            rd_mux = `MEM_BUS_ID_WORD; // Writes here are dropped.
        end else begin
            rd_mux = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (sel && !req_bus.wr) begin
            rd_q <= rd_mux;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= sel;
        end
    end

    assign rsp.ack     = ack_q;
    assign rsp.rd_data = rd_q;

endmodule

/* design/scratch_ram.sv */
`timescale 1ns/1ps
`include "mem_bus_settings.svh"

module scratch_ram (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  sel,
    input  mem_bus_pkg::mem_req_t req_bus,
    output mem_bus_pkg::mem_rsp_t rsp
);
    import mem_bus_pkg::*;

    logic [`MEM_BUS_DATA_WID-1:0]                          mem [`MEM_BUS_RAM_DEPTH];
    logic [`MEM_BUS_RAM_RD_LAT-1:0]                        rd_vld;
    logic [`MEM_BUS_RAM_RD_LAT-1:0][`MEM_BUS_DATA_WID-1:0] rd_pipe;
    logic                                                   wr_ack_q;
    logic                                                   rd_sel;
    logic                                                   wr_sel;
    logic [`MEM_BUS_OFFSET_WID-1:0]                        offset;

    assign rd_sel = sel && !req_bus.wr;
    assign wr_sel = sel && req_bus.wr;
    assign offset = req_bus.addr.fields.offset;

    always_ff @(posedge clk) begin
        if (wr_sel) begin
            mem[offset] <= req_bus.wr_data;
        end
    end

    // Read data shifts along with its valid bit.
    always_ff @(posedge clk) begin
        if (rd_sel) begin
            rd_pipe[0] <= mem[offset];
        end
        for (int i = 1; i < `MEM_BUS_RAM_RD_LAT; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld   <= '0;
            wr_ack_q <= 1'b0;
        end else begin
            rd_vld[0] <= rd_sel;
            for (int i = 1; i < `MEM_BUS_RAM_RD_LAT; i++) begin
                rd_vld[i] <= rd_vld[i-1];
            end
            wr_ack_q <= wr_sel; // Writes finish next cycle.
        end
    end

    assign rsp.ack     = wr_ack_q | rd_vld[`MEM_BUS_RAM_RD_LAT-1];
    assign rsp.rd_data = rd_pipe[`MEM_BUS_RAM_RD_LAT-1];

    // A write ack would collide with a pending read ack.
    a_no_wr_during_rd: assert property (@(posedge clk) disable iff (!rst_n)
        wr_sel |-> (rd_vld == '0));

endmodule

/* include/mem_bus_settings.svh */
`ifndef MEM_BUS_SETTINGS_SVH
`define MEM_BUS_SETTINGS_SVH

// Host address and data widths.
`define MEM_BUS_ADDR_WID 12
`define MEM_BUS_DATA_WID 32

// Word offset inside one region, upper address bits pick the region.
`define MEM_BUS_OFFSET_WID 10

// Scratch RAM geometry and read latency in cycles from select to ack.
`define MEM_BUS_RAM_DEPTH 1024
`define MEM_BUS_RAM_RD_LAT 2

// Constant returned by the register bank at offset 4.
`define MEM_BUS_ID_WORD 32'h4D42_4831

// Read value for the unmapped region.
`define MEM_BUS_UNMAPPED_DATA 32'hBADA_DD00

`endif

/* mem_bus_hub.f */
+incdir+include
design/mem_bus_pkg.sv
design/mem_bus_ctrl.sv
design/scratch_ram.sv
design/reg_bank.sv
design/event_counter.sv
design/mem_bus_hub.sv
tb/mem_bus_hub_tb.sv

/* tb/mem_bus_hub_tb.sv */
`timescale 1ns/1ps
`include "mem_bus_settings.svh"

module mem_bus_hub_tb;
    import mem_bus_pkg::*;

    logic                          clk;
    logic                          rst_n;
    logic                          req;
    logic                          wr;
    logic [`MEM_BUS_ADDR_WID-1:0] addr;
    logic [`MEM_BUS_DATA_WID-1:0] wr_data;
    logic                          rdy;
    logic                          wr_ack;
    logic                          rd_ack;
    logic [`MEM_BUS_DATA_WID-1:0] rd_data;
    logic                          event_in;
    logic                          irq;

    logic [31:0] lcg_state;
    logic [31:0] ram_model [int];
    logic [31:0] reg_model [4];
    logic [31:0] cnt_model;
    logic [31:0] cmp_model;
    logic        match_model;
    int          ram_written [$];

    mem_bus_hub u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .wr       (wr),
        .addr     (addr),
        .wr_data  (wr_data),
        .rdy      (rdy),
        .wr_ack   (wr_ack),
        .rd_ack   (rd_ack),
        .rd_data  (rd_data),
        .event_in (event_in),
        .irq      (irq)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return (lcg_next() >> 8) % n; // Low LCG bits are weak.
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi[31:16], lo[31:16]};
    endfunction

    function automatic logic [`MEM_BUS_ADDR_WID-1:0] make_addr(input int rg, input int off);
        mem_addr_u au;
        au.fields.region = mem_region_e'(rg[1:0]);
        au.fields.offset = off[`MEM_BUS_OFFSET_WID-1:0];
        return au.word;
    endfunction

    task automatic report_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_timeout(input string msg);
        $display("Timeout at %0t: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "stopped on a timeout");
    endtask

    function automatic logic [31:0] model_read(input logic [`MEM_BUS_ADDR_WID-1:0] a);
        mem_addr_u   au;
        logic [31:0] val;
        au.word = a;
        val = '0;
        case (au.fields.region)
            region_ram: val = ram_model[int'(au.fields.offset)];
            region_regs: begin
                if (au.fields.offset < 4) begin
                    val = reg_model[au.fields.offset[1:0]];
                end else if (au.fields.offset == 4) begin
                    val = `MEM_BUS_ID_WORD;
                end
            end
            region_counter: begin
                if (au.fields.offset == 0) begin
                    val = cnt_model;
                end else if (au.fields.offset == 1) begin
                    val = cmp_model;
                end else if (au.fields.offset == 2) begin
                    val = {31'b0, match_model};
                end
            end
            default: val = `MEM_BUS_UNMAPPED_DATA;
        endcase
        return val;
    endfunction

    task automatic model_write(input logic [`MEM_BUS_ADDR_WID-1:0] a, input logic [31:0] d);
        mem_addr_u au;
        au.word = a;
        case (au.fields.region)
            region_ram: ram_model[int'(au.fields.offset)] = d;
            region_regs: begin
                if (au.fields.offset < 4) begin
                    reg_model[au.fields.offset[1:0]] = d;
                end
            end
            region_counter: begin
                if (au.fields.offset == 0) begin
                    cnt_model = d;
                    if (cnt_model == cmp_model) begin
                        match_model = 1'b1;
                    end
                end else if (au.fields.offset == 1) begin
                    cmp_model = d;
                end else if (au.fields.offset == 2 && d[0]) begin
                    match_model = 1'b0;
                end
            end
            default: ;
        endcase
    endtask

    // Starts and ends 1 ns after a rising edge.
    task automatic bus_access(input logic w, input logic [`MEM_BUS_ADDR_WID-1:0] a,
                              input logic [31:0] d, output logic [31:0] q);
        int        wait_cnt;
        int        lat;
        int        exp_lat;
        mem_addr_u au;
        au.word = a;
        exp_lat = (!w && au.fields.region == region_ram) ? 2 + `MEM_BUS_RAM_RD_LAT : 3;
        wait_cnt = 0;
        while (!rdy) begin
            @(posedge clk);
            #1;
            wait_cnt++;
            if (wait_cnt > 50) report_timeout("rdy never went high for a new request");
        end
        req     = 1'b1;
        wr      = w;
        addr    = a;
        wr_data = d;
        @(posedge clk);
        #1;
        req = 1'b0; // Accepted at that edge.
        lat = 1;
        while (!(wr_ack || rd_ack)) begin
            assert (!rdy) else report_error("rdy high while a transaction is open");
            @(posedge clk);
            #1;
            lat++;
            if (lat > 50) report_timeout(w ? "wr_ack never came for a write"
                                           : "rd_ack never came for a read");
        end
        assert (!rdy) else report_error("rdy high in the acknowledge cycle");
        assert (wr_ack == w && rd_ack == !w)
            else report_error($sformatf("wrong ack for 0x%03h: wr_ack=%0b rd_ack=%0b",
                                        a, wr_ack, rd_ack));
        assert (lat == exp_lat)
            else report_error($sformatf("ack for 0x%03h after %0d cycles, expected %0d",
                                        a, lat, exp_lat));
        q = rd_data;
        @(posedge clk);
        #1;
        assert (rdy && !wr_ack && !rd_ack)
            else report_error("ack longer than one cycle or rdy not back high");
    endtask

    task automatic write_word(input logic [`MEM_BUS_ADDR_WID-1:0] a, input logic [31:0] d);
        logic [31:0] q;
        bus_access(1'b1, a, d, q);
        model_write(a, d);
    endtask

    task automatic read_check(input logic [`MEM_BUS_ADDR_WID-1:0] a);
        logic [31:0] q;
        logic [31:0] exp;
        exp = model_read(a);
        bus_access(1'b0, a, '0, q);
        assert (q === exp)
            else report_error($sformatf("read 0x%03h got 0x%08h, expected 0x%08h", a, q, exp));
    endtask

    // Even cycles always carry an event, odd ones are random.
    task automatic apply_events(input int cycles);
        logic ev;
        assert (rdy && !req) else report_error("events started during a transaction");
        for (int i = 0; i < cycles; i++) begin
            ev = (i % 2 == 0) || (rand_below(2) == 1);
            event_in = ev;
            @(posedge clk);
            #1;
            if (ev) begin
                cnt_model = cnt_model + 1;
                if (cnt_model == cmp_model) begin
                    match_model = 1'b1;
                end
            end
            assert (irq == match_model)
                else report_error($sformatf("irq=%0b, expected %0b", irq, match_model));
        end
        event_in = 1'b0;
    endtask

    initial begin
        int          k;
        int          n;
        int          rg;
        int          off;
        logic [31:0] base;
        lcg_state   = 32'd11;
        rst_n       = 1'b0;
        req         = 1'b0;
        wr          = 1'b0;
        addr        = '0;
        wr_data     = '0;
        event_in    = 1'b0;
        cnt_model   = '0;
        cmp_model   = '0;
        match_model = 1'b0;
        for (int i = 0; i < 4; i++) begin
            reg_model[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        assert (rdy && !wr_ack && !rd_ack && !irq) else report_error("wrong outputs after reset");
        for (int i = 0; i < 4; i++) begin
            read_check(make_addr(region_regs, i));
        end
        read_check(make_addr(region_counter, 0));
        read_check(make_addr(region_counter, 1));

        // RAM, some offsets written twice.
        for (int i = 0; i < 24; i++) begin
            off = (i > 4 && rand_below(4) == 0) ? ram_written[rand_below(ram_written.size())]
                                                : rand_below(`MEM_BUS_RAM_DEPTH);
            write_word(make_addr(region_ram, off), rand_word());
            ram_written.push_back(off);
        end
        for (int i = 0; i < 24; i++) begin
            read_check(make_addr(region_ram, ram_written[rand_below(ram_written.size())]));
        end

        for (int i = 0; i < 16; i++) begin
            write_word(make_addr(region_regs, rand_below(8)), rand_word());
            read_check(make_addr(region_regs, rand_below(8)));
        end
        write_word(make_addr(region_regs, 4), rand_word());
        read_check(make_addr(region_regs, 4));
        read_check(make_addr(region_regs, 700));

        for (int r = 0; r < 3; r++) begin
            base = rand_word();
            k    = 1 + rand_below(8);
            n    = k + rand_below(6);
            write_word(make_addr(region_counter, 2), 32'h1);
            write_word(make_addr(region_counter, 1), base + k);
            write_word(make_addr(region_counter, 0), base);
            assert (!irq) else report_error("irq high before the compare value was reached");
            apply_events(2 * n);
            assert (irq) else report_error("irq did not rise at the compare value");
            read_check(make_addr(region_counter, 0));
            read_check(make_addr(region_counter, 1));
            read_check(make_addr(region_counter, 2));
            write_word(make_addr(region_counter, 2), 32'h2); // Bit 0 clear, flag stays.
            assert (irq) else report_error("irq cleared by a write without bit 0");
            write_word(make_addr(region_counter, 2), 32'h1);
            assert (!irq) else report_error("irq still high after the flag was cleared");
            read_check(make_addr(region_counter, 2));
        end

        for (int i = 0; i < 8; i++) begin
            write_word(make_addr(region_unmapped, rand_below(1024)), rand_word());
            read_check(make_addr(region_unmapped, rand_below(1024)));
        end

        // Mixed traffic over every region.
        for (int i = 0; i < 32; i++) begin
            rg  = rand_below(4);
            off = (rg == 0) ? rand_below(`MEM_BUS_RAM_DEPTH) : rand_below(8);
            if (rand_below(2) == 1) begin
                write_word(make_addr(rg, off), rand_word());
                if (rg == 0) begin
                    ram_written.push_back(off);
                end
            end else begin
                if (rg == 0) begin
                    off = ram_written[rand_below(ram_written.size())];
                end
                read_check(make_addr(rg, off));
            end
            assert (irq == match_model)
                else report_error($sformatf("irq=%0b, expected %0b", irq, match_model));
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule
